// ==== bench/issue_core_tb.sv ====
`default_nettype none

`include "cpu_defs.svh"

module issue_core_tb import cpu_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int WAIT_LIMIT = 200;

logic                       clk;
logic                       rst_n;
logic                       push;
uint32_t                    push_instr;
logic                       ready;
logic      [`ISSUE_NUM-1:0] wb_valid;
reg_addr_t [`ISSUE_NUM-1:0] wb_rd;
uint32_t   [`ISSUE_NUM-1:0] wb_data;

uint32_t   model_regs [`REG_NUM];
reg_addr_t exp_rd [$];  // Expected retirements in program order.
uint32_t   exp_val [$];
int        accepted_writes = 0;
int        retired = 0;
int        errors = 0;
int        check_errors = 0;
int        tests = 0;
int        failed_tests = 0;
int        errors_before = 0;

tb_clock clock_inst (.clk, .rst_n);

issue_core issue_core_inst (
	.clk, .rst_n, .push, .push_instr, .ready,
	.wb_valid, .wb_rd, .wb_data
);

// ------------------------------
// Instruction encoding
// ------------------------------
function automatic uint32_t r_type(input logic [5:0] fn, input reg_addr_t rd,
                                   input reg_addr_t rs, input reg_addr_t rt,
                                   input logic [4:0] sh);
	return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic uint32_t i_type(input logic [5:0] op, input reg_addr_t rt,
                                   input reg_addr_t rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic reg_addr_t rand_reg(input int lo, input int hi);
	return 5'(lo + $urandom % (hi - lo + 1));
endfunction

// Kinds 0 to 11 are the supported ops. Anything else is a nop.
function automatic uint32_t make_instr(input int kind, input reg_addr_t d,
                                       input reg_addr_t s, input reg_addr_t t);
	logic [15:0] imm;
	imm = 16'($urandom);
	case (kind)
		0:       return r_type(FN_ADDU, d, s, t, 5'd0);
		1:       return r_type(FN_SUBU, d, s, t, 5'd0);
		2:       return r_type(FN_AND, d, s, t, 5'd0);
		3:       return r_type(FN_OR, d, s, t, 5'd0);
		4:       return r_type(FN_XOR, d, s, t, 5'd0);
		5:       return r_type(FN_SLT, d, s, t, 5'd0);
		6:       return r_type(FN_SLL, d, 5'd0, t, 5'($urandom));
		7:       return i_type(OP_ADDIU, d, s, imm);
		8:       return i_type(OP_ANDI, d, s, imm);
		9:       return i_type(OP_ORI, d, s, imm);
		10:      return i_type(OP_XORI, d, s, imm);
		11:      return i_type(OP_LUI, d, 5'd0, imm);
		default: return 32'h0000_0000;
	endcase
endfunction

// ------------------------------
// Reference model
// ------------------------------
task automatic run_model(input uint32_t w);
	uint32_t   a;
	uint32_t   b;
	uint32_t   v;
	reg_addr_t dest;
	logic      writes;
	a      = model_regs[w[25:21]];
	b      = model_regs[w[20:16]];
	v      = '0;
	dest   = w[20:16]; // I-format target is rt.
	writes = 1'b1;
	case (w[31:26])
		OP_SPECIAL: begin
			dest = w[15:11];
			case (w[5:0])
				FN_ADDU: v = a + b;
				FN_SUBU: v = a - b;
				FN_AND:  v = a & b;
				FN_OR:   v = a | b;
				FN_XOR:  v = a ^ b;
				FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_SLL:  v = b << w[10:6];
				default: writes = 1'b0;
			endcase
		end
		OP_ADDIU: v = a + {{16{w[15]}}, w[15:0]};
		OP_ANDI:  v = a & {16'h0000, w[15:0]};
		OP_ORI:   v = a | {16'h0000, w[15:0]};
		OP_XORI:  v = a ^ {16'h0000, w[15:0]};
		OP_LUI:   v = {w[15:0], 16'h0000};
		default:  writes = 1'b0;
	endcase
	if (writes && dest != 5'd0) begin
		model_regs[dest] = v;
		exp_rd.push_back(dest);
		exp_val.push_back(v);
		accepted_writes++;
	end
endtask

// ------------------------------
// Stimulus
// ------------------------------
// Called on a rising edge. Holds the word until the queue takes it.
task automatic send(input uint32_t w);
	int t;
	push       <= 1'b1;
	push_instr <= w;
	t = 0;
	@(negedge clk);
	while (!ready && t < WAIT_LIMIT) begin
		@(negedge clk);
		t++;
	end
	if (ready) begin
		run_model(w); // Taken on the coming edge.
	end else begin
		errors++;
		$display("timeout: ready stayed low while offering %08h", w);
	end
	@(posedge clk);
endtask

task automatic end_test(input string name);
	int t;
	push <= 1'b0;
	t = 0;
	while (exp_rd.size() > 0 && t < WAIT_LIMIT) begin
		@(negedge clk);
		t++;
	end
	@(posedge clk);
	assert (exp_rd.size() == 0) else begin
		errors++;
		$display("timeout: %0d expected writes never retired", exp_rd.size());
	end
	assert (retired == accepted_writes) else begin
		errors++;
		$display("mismatch retire_count: got %0h, expected %0h", retired, accepted_writes);
	end
	tests++;
	if (errors + check_errors != errors_before) begin
		failed_tests++;
		$display("test %0d %s: failed with %0d errors", tests, name,
		         errors + check_errors - errors_before);
	end else begin
		$display("test %0d %s: ok", tests, name);
	end
	errors_before = errors + check_errors;
endtask

// ------------------------------
// Retirement checks
// ------------------------------
always @(negedge clk) begin
	if (rst_n) begin
		for (int lane = 0; lane < `ISSUE_NUM; lane++) begin
			if (wb_valid[lane]) begin
				retired++;
				assert (exp_rd.size() > 0) else begin
					check_errors++;
					$display("lane %0d retired a write that was never accepted", lane);
				end
				if (exp_rd.size() > 0) begin
					assert (wb_rd[lane] == exp_rd[0]) else begin
						check_errors++;
						$display("mismatch wb_rd[%0d]: got %02h, expected %02h",
						         lane, wb_rd[lane], exp_rd[0]);
					end
					assert (wb_data[lane] == exp_val[0]) else begin
						check_errors++;
						$display("mismatch wb_data[%0d]: got %08h, expected %08h",
						         lane, wb_data[lane], exp_val[0]);
					end
					void'(exp_rd.pop_front());
					void'(exp_val.pop_front());
				end
			end
		end
	end
end

initial begin
	reg_addr_t d;
	int        t;
	void'($urandom(32'hb6f9));
	push       = 1'b0;
	push_instr = '0;
	for (int r = 0; r < `REG_NUM; r++) begin
		model_regs[r] = '0;
	end
	t = 0;
	while (rst_n !== 1'b1 && t < WAIT_LIMIT) begin
		@(negedge clk);
		t++;
	end
	@(posedge clk);

	// Idle core after reset.
	for (int k = 0; k < 6; k++) begin
		@(negedge clk);
		assert (ready == 1'b1) else begin
			errors++;
			$display("mismatch ready: got %0h, expected 1", ready);
		end
		assert (wb_valid == '0) else begin
			errors++;
			$display("mismatch wb_valid: got %0h, expected 0", wb_valid);
		end
	end
	@(posedge clk);
	end_test("reset state");

	for (int r = 1; r < `REG_NUM; r++) begin
		send(i_type(OP_LUI, 5'(r), 5'd0, 16'($urandom)));
		send(i_type(OP_ORI, 5'(r), 5'(r), 16'($urandom)));
	end
	for (int k = 0; k < 52; k++) begin
		send(make_instr(k % 13, rand_reg(1, 31), rand_reg(0, 31), rand_reg(0, 31)));
	end
	end_test("every op kind");

	// Fillers use r16 to r31 so the chain register is untouched in between.
	for (int gap = 0; gap < 4; gap++) begin
		for (int k = 0; k < 6; k++) begin
			d = rand_reg(1, 15);
			send(make_instr($urandom % 6, d, rand_reg(1, 15), rand_reg(1, 15)));
			for (int f = 0; f < gap; f++) begin
				send(make_instr(7 + $urandom % 4, rand_reg(16, 31), rand_reg(16, 31), 5'd0));
			end
			send(make_instr($urandom % 6, rand_reg(1, 15), d, rand_reg(1, 15)));
		end
	end
	end_test("dependent chains");

	for (int k = 0; k < 20; k++) begin
		d = rand_reg(1, 31);
		send(make_instr($urandom % 12, d, rand_reg(0, 31), rand_reg(0, 31)));
		if ($urandom % 2 == 0) begin
			send(make_instr($urandom % 6, rand_reg(1, 31), d, rand_reg(0, 31)));
		end else begin
			send(make_instr(7 + $urandom % 5, d, rand_reg(0, 31), 5'd0));
		end
	end
	end_test("paired hazards");

	for (int k = 0; k < 48; k++) begin
		send(make_instr($urandom % 13, rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31)));
	end
	end_test("push burst");

	for (int k = 0; k < 4; k++) begin
		send(make_instr($urandom % 12, 5'd0, rand_reg(1, 31), rand_reg(1, 31)));
		send(make_instr(0, rand_reg(1, 31), 5'd0, 5'd0));
		send(make_instr(3, rand_reg(1, 31), 5'd0, rand_reg(1, 31)));
		send(i_type(OP_ORI, rand_reg(1, 31), 5'd0, 16'($urandom)));
	end
	end_test("r0 stays zero");

	$display("tests %0d, failed %0d, retired %0d, errors %0d",
	         tests, failed_tests, retired, errors + check_errors);
	if (errors + check_errors == 0) begin
		$display(">>> PASS");
	end else begin
		$display(">>> FAIL");
	end
	$finish;
end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

timeunit 1ns;
timeprecision 100ps;

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk; // 4 ns period.
end

initial begin
	rst_n = 1'b0;
	repeat (3) @(posedge clk);
	rst_n <= 1'b1;
end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/instr_queue.sv
logic/decoder.sv
logic/register_forward.sv
logic/instr_issue.sv
logic/decode_and_issue.sv
logic/regfile.sv
logic/exec_pipe.sv
logic/issue_core.sv
bench/tb_clock.sv
bench/issue_core_tb.sv

// ==== logic/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ------------------------------
// Core sizing
// ------------------------------

// Instructions looked at and issued per cycle.
`define ISSUE_NUM   2

// Instruction queue entries, a power of two so the pointers wrap on their own.
`define QUEUE_DEPTH 8

// Architectural integer registers.
`define REG_NUM     32

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI,
		ALU_SLL
	} alu_op_t;

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;       // Zero when nothing is written.
		logic      use_imm;
		uint32_t   imm;      // Already extended.
		logic [4:0] shamt;
		alu_op_t   alu_op;
		logic      we;
	} decoded_instr_t;

	// ------------------------------
	// MIPS32 encodings
	// ------------------------------
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// Function field of OP_SPECIAL.
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_SLT     = 6'h2a;

endpackage

`default_nettype wire

// ==== logic/decode_and_issue.sv ====
`default_nettype none

`include "cpu_defs.svh"

module decode_and_issue import cpu_pkg::*; (
	input  logic           [`ISSUE_NUM-1:0]         head_valid,
	input  uint32_t        [`ISSUE_NUM-1:0]         head_instr,

	input  logic           [`ISSUE_NUM-1:0]         ex_we,
	input  reg_addr_t      [`ISSUE_NUM-1:0]         ex_waddr,
	input  uint32_t        [`ISSUE_NUM-1:0]         ex_wdata,
	input  logic           [`ISSUE_NUM-1:0]         mem_we,
	input  reg_addr_t      [`ISSUE_NUM-1:0]         mem_waddr,
	input  uint32_t        [`ISSUE_NUM-1:0]         mem_wdata,
	input  logic           [`ISSUE_NUM-1:0]         wb_we,
	input  reg_addr_t      [`ISSUE_NUM-1:0]         wb_waddr,
	input  uint32_t        [`ISSUE_NUM-1:0]         wb_wdata,

	output reg_addr_t      [`ISSUE_NUM*2-1:0]       reg_raddr,
	input  uint32_t        [`ISSUE_NUM*2-1:0]       reg_rdata,

	output logic           [`ISSUE_NUM-1:0]         iss_valid,
	output decoded_instr_t [`ISSUE_NUM-1:0]         iss_decoded,
	output uint32_t        [`ISSUE_NUM-1:0]         iss_reg1,
	output uint32_t        [`ISSUE_NUM-1:0]         iss_reg2,
	output logic           [$clog2(`ISSUE_NUM+1)-1:0] issue_num
);

logic stall_req;

for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_slot
	decoder decoder_inst (
		.instr         ( head_instr[i]  ),
		.decoded_instr ( iss_decoded[i] )
	);

	assign reg_raddr[i*2]   = iss_decoded[i].rs1;
	assign reg_raddr[i*2+1] = iss_decoded[i].rs2;

	register_forward reg_forward_inst (
		.decoded_instr ( iss_decoded[i]     ),
		.reg1_i        ( reg_rdata[i*2]     ),
		.reg2_i        ( reg_rdata[i*2+1]   ),
		.ex_we, .ex_waddr, .ex_wdata,
		.mem_we, .mem_waddr, .mem_wdata,
		.wb_we, .wb_waddr, .wb_wdata,
		.reg1_o        ( iss_reg1[i]        ),
		.reg2_o        ( iss_reg2[i]        )
	);

	// Younger slots drop out whenever the pair is split.
	assign iss_valid[i] = head_valid[i] && (i == 0 || !stall_req);
end

instr_issue issue_inst (
	.instr_valid ( head_valid  ),
	.id_decoded  ( iss_decoded ),
	.issue_num,
	.stall_req
);

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
`default_nettype none

module decoder import cpu_pkg::*; (
	input  uint32_t        instr,
	output decoded_instr_t decoded_instr
);

logic [5:0] opcode;
logic [5:0] funct;
reg_addr_t  rs;
reg_addr_t  rt;
reg_addr_t  rd;
logic       known;

assign opcode = instr[31:26];
assign funct  = instr[5:0];
assign rs     = instr[25:21];
assign rt     = instr[20:16];
assign rd     = instr[15:11];

always_comb begin
	decoded_instr = '0;
	known         = 1'b1;
	case (opcode)
		OP_SPECIAL: begin
			decoded_instr.rs1   = rs;
			decoded_instr.rs2   = rt;
			decoded_instr.rd    = rd;
			decoded_instr.shamt = instr[10:6];
			case (funct)
				FN_ADDU: decoded_instr.alu_op = ALU_ADD;
				FN_SUBU: decoded_instr.alu_op = ALU_SUB;
				FN_AND:  decoded_instr.alu_op = ALU_AND;
				FN_OR:   decoded_instr.alu_op = ALU_OR;
				FN_XOR:  decoded_instr.alu_op = ALU_XOR;
				FN_SLT:  decoded_instr.alu_op = ALU_SLT;
				FN_SLL: begin
					decoded_instr.alu_op = ALU_SLL;
					decoded_instr.rs1    = '0; // Shifts rt only.
				end
				default: known = 1'b0;
			endcase
		end
		OP_ADDIU: begin
			decoded_instr.rs1     = rs;
			decoded_instr.rd      = rt;
			decoded_instr.use_imm = 1'b1;
			decoded_instr.imm     = {{16{instr[15]}}, instr[15:0]}; // Sign extended.
			decoded_instr.alu_op  = ALU_ADD;
		end
		OP_ANDI, OP_ORI, OP_XORI: begin
			decoded_instr.rs1     = rs;
			decoded_instr.rd      = rt;
			decoded_instr.use_imm = 1'b1;
			decoded_instr.imm     = {16'h0000, instr[15:0]}; // Zero extended.
			decoded_instr.alu_op  = (opcode == OP_ANDI) ? ALU_AND :
			                        (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
		end
		OP_LUI: begin
			decoded_instr.rd      = rt;
			decoded_instr.use_imm = 1'b1;
			decoded_instr.imm     = {instr[15:0], 16'h0000};
			decoded_instr.alu_op  = ALU_LUI;
		end
		default: known = 1'b0;
	endcase

	// Unknown words and anything aimed at r0 become a plain nop.
	decoded_instr.we = known && (decoded_instr.rd != '0);
	if (!decoded_instr.we) begin
		decoded_instr = '0;
	end
end

endmodule

`default_nettype wire

// ==== logic/exec_pipe.sv ====
`default_nettype none

`include "cpu_defs.svh"

module exec_pipe import cpu_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic           [`ISSUE_NUM-1:0]   iss_valid,
	input  decoded_instr_t [`ISSUE_NUM-1:0]   iss_decoded,
	input  uint32_t        [`ISSUE_NUM-1:0]   iss_reg1,
	input  uint32_t        [`ISSUE_NUM-1:0]   iss_reg2,
	output logic           [`ISSUE_NUM-1:0]   ex_we,
	output reg_addr_t      [`ISSUE_NUM-1:0]   ex_waddr,
	output uint32_t        [`ISSUE_NUM-1:0]   ex_wdata,
	output logic           [`ISSUE_NUM-1:0]   mem_we,
	output reg_addr_t      [`ISSUE_NUM-1:0]   mem_waddr,
	output uint32_t        [`ISSUE_NUM-1:0]   mem_wdata,
	output logic           [`ISSUE_NUM-1:0]   wb_we,
	output reg_addr_t      [`ISSUE_NUM-1:0]   wb_waddr,
	output uint32_t        [`ISSUE_NUM-1:0]   wb_wdata,
	output logic           [`ISSUE_NUM-1:0]   wb_valid
);

alu_op_t [`ISSUE_NUM-1:0]      ex_op;
logic    [`ISSUE_NUM-1:0][4:0] ex_shamt;
uint32_t [`ISSUE_NUM-1:0]      ex_op1;
uint32_t [`ISSUE_NUM-1:0]      ex_op2;

// ------------------------------
// Stage control
// ------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		ex_we  <= '0;
		mem_we <= '0;
		wb_we  <= '0;
	end else begin
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			ex_we[i] <= iss_valid[i] & iss_decoded[i].we;
		end
		mem_we <= ex_we;
		wb_we  <= mem_we;
	end
end

// ------------------------------
// Stage payload
// ------------------------------
always_ff @(posedge clk) begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		ex_waddr[i] <= iss_decoded[i].rd;
		ex_op[i]    <= iss_decoded[i].alu_op;
		ex_shamt[i] <= iss_decoded[i].shamt;
		ex_op1[i]   <= iss_reg1[i];
		ex_op2[i]   <= iss_decoded[i].use_imm ? iss_decoded[i].imm : iss_reg2[i];
	end
	mem_waddr <= ex_waddr;
	mem_wdata <= ex_wdata;
	wb_waddr  <= mem_waddr;
	wb_wdata  <= mem_wdata;
end

always_comb begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		case (ex_op[i])
			ALU_ADD: ex_wdata[i] = ex_op1[i] + ex_op2[i];
			ALU_SUB: ex_wdata[i] = ex_op1[i] - ex_op2[i];
			ALU_AND: ex_wdata[i] = ex_op1[i] & ex_op2[i];
			ALU_OR:  ex_wdata[i] = ex_op1[i] | ex_op2[i];
			ALU_XOR: ex_wdata[i] = ex_op1[i] ^ ex_op2[i];
			ALU_SLT: ex_wdata[i] = {31'b0, $signed(ex_op1[i]) < $signed(ex_op2[i])};
			ALU_LUI: ex_wdata[i] = ex_op2[i]; // Immediate comes pre-shifted.
			ALU_SLL: ex_wdata[i] = ex_op2[i] << ex_shamt[i];
			default: ex_wdata[i] = '0;
		endcase
	end
end

assign wb_valid = wb_we; // Only writing instructions are reported at retire.

endmodule

`default_nettype wire

// ==== logic/instr_issue.sv ====
`default_nettype none

`include "cpu_defs.svh"

module instr_issue import cpu_pkg::*; (
	input  logic           [`ISSUE_NUM-1:0]       instr_valid,
	input  decoded_instr_t [`ISSUE_NUM-1:0]       id_decoded,
	output logic           [$clog2(`ISSUE_NUM+1)-1:0] issue_num,
	output logic                                  stall_req
);

localparam int CNT_W = $clog2(`ISSUE_NUM + 1);

logic raw_hazard;
logic waw_hazard;

// A set we bit implies a nonzero rd, so r0 never causes a hazard.
assign raw_hazard = id_decoded[0].we &&
                    (id_decoded[1].rs1 == id_decoded[0].rd ||
                     id_decoded[1].rs2 == id_decoded[0].rd);

assign waw_hazard = id_decoded[0].we && id_decoded[1].we &&
                    (id_decoded[1].rd == id_decoded[0].rd);

assign stall_req = instr_valid[1] && (raw_hazard || waw_hazard);

always_comb begin
	if (!instr_valid[0]) begin
		issue_num = '0;
	end else if (instr_valid[1] && !stall_req) begin
		issue_num = CNT_W'(2); // Pair goes out together.
	end else begin
		issue_num = CNT_W'(1);
	end
end

endmodule

`default_nettype wire

// ==== logic/instr_queue.sv ====
`default_nettype none

`include "cpu_defs.svh"

module instr_queue import cpu_pkg::*; (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                push,
	input  uint32_t                             push_instr,
	output logic                                ready,
	input  logic [$clog2(`ISSUE_NUM+1)-1:0]     pop_num,
	output logic    [`ISSUE_NUM-1:0]            head_valid,
	output uint32_t [`ISSUE_NUM-1:0]            head_instr
);

localparam int PTR_W = $clog2(`QUEUE_DEPTH);
localparam int CNT_W = PTR_W + 1;

uint32_t          mem [`QUEUE_DEPTH];
logic [PTR_W-1:0] rptr;
logic [PTR_W-1:0] wptr;
logic [CNT_W-1:0] count;
logic             push_ok;

assign ready   = (count != CNT_W'(`QUEUE_DEPTH));
assign push_ok = push & ready; // A push while full is dropped.

always_ff @(posedge clk) begin
	if (push_ok) begin
		mem[wptr] <= push_instr;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		rptr  <= '0;
		wptr  <= '0;
		count <= '0;
	end else begin
		if (push_ok) begin
			wptr <= wptr + 1'b1;
		end
		rptr  <= rptr + PTR_W'(pop_num); // Issue never pops more than is valid.
		count <= count + CNT_W'(push_ok) - CNT_W'(pop_num);
	end
end

// ------------------------------
// Oldest entries, slot 0 first
// ------------------------------
for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_head
	assign head_valid[i] = (count > CNT_W'(i));
	assign head_instr[i] = mem[rptr + PTR_W'(i)];
end

endmodule

`default_nettype wire

// ==== logic/issue_core.sv ====
`default_nettype none

`include "cpu_defs.svh"

module issue_core import cpu_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          push,
	input  uint32_t                       push_instr,
	output logic                          ready,
	output logic      [`ISSUE_NUM-1:0]    wb_valid,
	output reg_addr_t [`ISSUE_NUM-1:0]    wb_rd,
	output uint32_t   [`ISSUE_NUM-1:0]    wb_data
);

logic           [`ISSUE_NUM-1:0]           head_valid;
uint32_t        [`ISSUE_NUM-1:0]           head_instr;
logic           [$clog2(`ISSUE_NUM+1)-1:0] issue_num;
reg_addr_t      [`ISSUE_NUM*2-1:0]         reg_raddr;
uint32_t        [`ISSUE_NUM*2-1:0]         reg_rdata;
logic           [`ISSUE_NUM-1:0]           iss_valid;
decoded_instr_t [`ISSUE_NUM-1:0]           iss_decoded;
uint32_t        [`ISSUE_NUM-1:0]           iss_reg1;
uint32_t        [`ISSUE_NUM-1:0]           iss_reg2;
logic           [`ISSUE_NUM-1:0]           ex_we, mem_we, wb_we;
reg_addr_t      [`ISSUE_NUM-1:0]           ex_waddr, mem_waddr;
uint32_t        [`ISSUE_NUM-1:0]           ex_wdata, mem_wdata;

instr_queue queue_inst (
	.clk, .rst_n, .push, .push_instr, .ready,
	.pop_num    ( issue_num  ), // Pops whatever issues this cycle.
	.head_valid, .head_instr
);

decode_and_issue dai_inst (
	.head_valid, .head_instr,
	.ex_we, .ex_waddr, .ex_wdata,
	.mem_we, .mem_waddr, .mem_wdata,
	.wb_we, .wb_waddr ( wb_rd ), .wb_wdata ( wb_data ),
	.reg_raddr, .reg_rdata,
	.iss_valid, .iss_decoded, .iss_reg1, .iss_reg2,
	.issue_num
);

regfile regfile_inst (
	.clk, .rst_n,
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata ),
	.we    ( wb_we     ), // Written from WB.
	.waddr ( wb_rd     ),
	.wdata ( wb_data   )
);

exec_pipe pipe_inst (
	.clk, .rst_n,
	.iss_valid, .iss_decoded, .iss_reg1, .iss_reg2,
	.ex_we, .ex_waddr, .ex_wdata,
	.mem_we, .mem_waddr, .mem_wdata,
	.wb_we, .wb_waddr ( wb_rd ), .wb_wdata ( wb_data ),
	.wb_valid
);

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`default_nettype none

`include "cpu_defs.svh"

module regfile import cpu_pkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	input  reg_addr_t [`ISSUE_NUM*2-1:0]    raddr,
	output uint32_t   [`ISSUE_NUM*2-1:0]    rdata,
	input  logic      [`ISSUE_NUM-1:0]      we,
	input  reg_addr_t [`ISSUE_NUM-1:0]      waddr,
	input  uint32_t   [`ISSUE_NUM-1:0]      wdata
);

uint32_t regs [`REG_NUM];

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int r = 0; r < `REG_NUM; r++) begin
			regs[r] <= '0;
		end
	end else begin
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			if (we[i] && waddr[i] != '0) begin
				regs[waddr[i]] <= wdata[i]; // Lane 1 lands last.
			end
		end
	end
end

for (genvar p = 0; p < `ISSUE_NUM*2; ++p) begin : gen_read
	assign rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
end

endmodule

`default_nettype wire

// ==== logic/register_forward.sv ====
`default_nettype none

`include "cpu_defs.svh"

module register_forward import cpu_pkg::*; (
	input  decoded_instr_t                decoded_instr,
	input  uint32_t                       reg1_i,
	input  uint32_t                       reg2_i,
	input  logic      [`ISSUE_NUM-1:0]    ex_we,
	input  reg_addr_t [`ISSUE_NUM-1:0]    ex_waddr,
	input  uint32_t   [`ISSUE_NUM-1:0]    ex_wdata,
	input  logic      [`ISSUE_NUM-1:0]    mem_we,
	input  reg_addr_t [`ISSUE_NUM-1:0]    mem_waddr,
	input  uint32_t   [`ISSUE_NUM-1:0]    mem_wdata,
	input  logic      [`ISSUE_NUM-1:0]    wb_we,
	input  reg_addr_t [`ISSUE_NUM-1:0]    wb_waddr,
	input  uint32_t   [`ISSUE_NUM-1:0]    wb_wdata,
	output uint32_t                       reg1_o,
	output uint32_t                       reg2_o
);

// Later matches override earlier ones, so the loop order sets the priority.
function automatic uint32_t select_operand(input reg_addr_t addr, input uint32_t rf_data);
	uint32_t value;
	value = rf_data;
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		if (wb_we[i] && wb_waddr[i] == addr) value = wb_wdata[i];
	end
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		if (mem_we[i] && mem_waddr[i] == addr) value = mem_wdata[i];
	end
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		if (ex_we[i] && ex_waddr[i] == addr) value = ex_wdata[i]; // Younger lane last.
	end
	if (addr == '0) begin
		value = '0;
	end
	return value;
endfunction

assign reg1_o = select_operand(decoded_instr.rs1, reg1_i);
assign reg2_o = select_operand(decoded_instr.rs2, reg2_i);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles and runs the issue_core testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
	--top-module issue_core_tb -o issue_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/issue_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
